//--- Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build folder and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f all.f --top-module tb_barrel_display \
		-Mdir build -o sim_tb
	./build/sim_tb > $(LOG) 2>&1; cat $(LOG)
	grep -q "^Test OK$$" $(LOG)

clean:
	rm -rf build $(LOG)

//--- all.f
logic/shift_pkg.sv
logic/tick_gen.sv
logic/button_debounce.sv
logic/shift_control.sv
logic/barrel_shifter16.sv
logic/seg7_scan.sv
logic/barrel_display_top.sv
tb/tb_barrel_display.sv

//--- logic/barrel_display_top.sv
`timescale 1ns/100ps

module barrel_display_top import shift_pkg::*; #(
    // 100 MHz board clock down to a 1 kHz tick
    parameter int TICK_DIV       = 100_000,
    parameter int DEBOUNCE_TICKS = 20
) (
    input  logic       clk,
    input  logic       rst_n,
    input  data_word_t sw,
    input  logic [4:0] btn,
    output logic [7:0] led,
    output logic [6:0] seg,
    output logic       dp,
    output logic [7:0] an
);

    logic        tick;
    shift_ctrl_t ctrl;
    data_word_t  shifted;
    hex_digit_t  digits [NUM_DIGITS];

    //////////////////////////////
    // Tick and controls
    //////////////////////////////

    tick_gen #(
        .TICK_DIV(TICK_DIV)
    ) u_tick_gen (
        .clk  (clk),
        .rst_n(rst_n),
        .tick (tick)
    );

    shift_control #(
        .DEBOUNCE_TICKS(DEBOUNCE_TICKS)
    ) u_shift_control (
        .clk  (clk),
        .rst_n(rst_n),
        .tick (tick),
        .btn  (btn),
        .ctrl (ctrl)
    );

    // Settings mirrored on the LEDs
    assign led = {ctrl.dir, ctrl.rotate, ctrl.shamnt, 2'b00};

    //////////////////////////////
    // Shifter and display
    //////////////////////////////

    barrel_shifter16 u_barrel_shifter16 (
        .clk     (clk),
        .rst_n   (rst_n),
        .data_in (sw),
        .ctrl    (ctrl),
        .data_out(shifted)
    );

    // Digit 0 is the low nibble
    for (genvar i = 0; i < NUM_DIGITS; i++) begin : g_digit
        assign digits[i] = shifted[4*i +: 4];
    end

    seg7_scan u_seg7_scan (
        .clk   (clk),
        .rst_n (rst_n),
        .tick  (tick),
        .digits(digits),
        .seg   (seg),
        .an    (an[NUM_DIGITS-1:0])
    );

    // Unused digits and decimal point stay dark
    assign an[7:NUM_DIGITS] = '1;
    assign dp = 1'b1;

endmodule

//--- logic/barrel_shifter16.sv
`timescale 1ns/100ps

module barrel_shifter16 import shift_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  data_word_t  data_in,
    input  shift_ctrl_t ctrl,
    output data_word_t  data_out
);

    localparam int DW = $bits(data_word_t);

    // stage[0] is the input, stage[4] the fully shifted word
    data_word_t stage [5];

    assign stage[0] = data_in;

    //////////////////////////////
    // Log shifter, 1 2 4 8
    //////////////////////////////

    for (genvar k = 0; k < 4; k++) begin : g_stage
        localparam int SH = 1 << k;

        // Bits entering from the right on a left shift, and vice versa
        logic [SH-1:0] fill_l;
        logic [SH-1:0] fill_r;

        // Rotation recycles the bits pushed out
        assign fill_l = ctrl.rotate ? stage[k][DW-1 -: SH] : '0;
        assign fill_r = ctrl.rotate ? stage[k][SH-1:0] : '0;

        assign stage[k+1] = !ctrl.shamnt[k]           ? stage[k] :
                            (ctrl.dir == SHIFT_LEFT)  ? {stage[k][DW-SH-1:0], fill_l} :
                                                        {fill_r, stage[k][DW-1:SH]};
    end

    // Output register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            data_out <= '0;
        end else begin
            data_out <= stage[4];
        end
    end

    // A rotation never loses or gains a set bit
    a_rot_ones : assert property (@(posedge clk) disable iff (!rst_n)
        ctrl.rotate |=> $countones(data_out) == $countones($past(data_in)));

endmodule

//--- logic/button_debounce.sv
`timescale 1ns/100ps

module button_debounce #(
    parameter int DEBOUNCE_TICKS = 20
) (
    input  logic clk,
    input  logic rst_n,
    input  logic tick,
    input  logic btn,
    output logic toggle,
    output logic press
);

    localparam int CNT_W = $clog2(DEBOUNCE_TICKS + 1);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(DEBOUNCE_TICKS - 1);

    logic             btn_meta;
    logic             btn_sync;
    logic             level;
    logic [CNT_W-1:0] stable_cnt;
    logic             flip;

    //////////////////////////////
    // Synchronizer
    //////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            btn_meta <= 1'b0;
            btn_sync <= 1'b0;
        end else begin
            btn_meta <= btn;
            btn_sync <= btn_meta;
        end
    end

    //////////////////////////////
    // Stability counter
    //////////////////////////////

    // Last differing sample on a tick completes the run
    assign flip = tick && (btn_sync != level) && (stable_cnt == CNT_LAST);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stable_cnt <= '0;
            level      <= 1'b0;
            toggle     <= 1'b0;
            press      <= 1'b0;
        end else begin
            // Press is a one-cycle pulse
            press <= 1'b0;
            if (tick) begin
                if (btn_sync == level) begin
                    // Bounce back, start over
                    stable_cnt <= '0;
                end else if (flip) begin
                    stable_cnt <= '0;
                    level      <= btn_sync;
                    // Rising accepted edge only
                    if (btn_sync) begin
                        press  <= 1'b1;
                        toggle <= ~toggle;
                    end
                end else begin
                    stable_cnt <= stable_cnt + 1'b1;
                end
            end
        end
    end

    // Press only ever seen with the button accepted down
    a_press_level : assert property (@(posedge clk) disable iff (!rst_n)
        press |-> level);

endmodule

//--- logic/seg7_scan.sv
`timescale 1ns/100ps

module seg7_scan import shift_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  tick,
    input  hex_digit_t            digits [NUM_DIGITS],
    output logic [6:0]            seg,
    output logic [NUM_DIGITS-1:0] an
);

    localparam int IDX_W = (NUM_DIGITS > 1) ? $clog2(NUM_DIGITS) : 1;
    localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(NUM_DIGITS - 1);

    logic [IDX_W-1:0] idx;
    // Set by the first tick, the display is live from then on
    logic             started;

    //////////////////////////////
    // Hex decode
    //////////////////////////////

    // Active low, gfedcba
    function automatic logic [6:0] hex_to_seg(input hex_digit_t d);
        case (d)
            4'h0: return 7'b100_0000;
            4'h1: return 7'b111_1001;
            4'h2: return 7'b010_0100;
            4'h3: return 7'b011_0000;
            4'h4: return 7'b001_1001;
            4'h5: return 7'b001_0010;
            4'h6: return 7'b000_0010;
            4'h7: return 7'b111_1000;
            4'h8: return 7'b000_0000;
            4'h9: return 7'b001_0000;
            4'ha: return 7'b000_1000;
            4'hb: return 7'b000_0011;
            4'hc: return 7'b100_0110;
            4'hd: return 7'b010_0001;
            4'he: return 7'b000_0110;
            default: return 7'b000_1110;
        endcase
    endfunction

    //////////////////////////////
    // Scan
    //////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idx     <= '0;
            started <= 1'b0;
            seg     <= SEG_BLANK;
            an      <= '1;
        end else if (tick) begin
            started <= 1'b1;
            // Digit value latched with its anode
            seg     <= hex_to_seg(digits[idx]);
            an      <= ~(NUM_DIGITS'(1) << idx);
            // Wrap for any digit count
            if (idx == IDX_LAST) begin
                idx <= '0;
            end else begin
                idx <= idx + 1'b1;
            end
        end
    end

    // Once scanning, exactly one digit lit
    a_an_onehot : assert property (@(posedge clk) disable iff (!rst_n)
        started |-> $onehot(~an));

endmodule

//--- logic/shift_control.sv
`timescale 1ns/100ps

module shift_control import shift_pkg::*; #(
    parameter int DEBOUNCE_TICKS = 20
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        tick,
    input  logic [4:0]  btn,
    output shift_ctrl_t ctrl
);

    // Debounced outputs, one bit per button
    logic [4:0] toggle;
    logic [4:0] press;

    //////////////////////////////
    // Button debouncers
    //////////////////////////////

    // 0 dir, 1 rotate, 2 shamnt[0], 3 shamnt[1], 4 shamnt[3:2] step
    for (genvar i = 0; i < 5; i++) begin : g_btn
        button_debounce #(
            .DEBOUNCE_TICKS(DEBOUNCE_TICKS)
        ) u_button_debounce (
            .clk   (clk),
            .rst_n (rst_n),
            .tick  (tick),
            .btn   (btn[i]),
            .toggle(toggle[i]),
            .press (press[i])
        );
    end

    //////////////////////////////
    // Control register
    //////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl <= '0;
        end else begin
            // Toggle levels follow one cycle behind the press
            ctrl.dir         <= shift_dir_e'(toggle[0]);
            ctrl.rotate      <= toggle[1];
            ctrl.shamnt[1:0] <= toggle[3:2];
            // High pair counts presses, wraps 3 -> 0
            if (press[4]) begin
                ctrl.shamnt[3:2] <= ctrl.shamnt[3:2] + 2'd1;
            end
        end
    end

endmodule

//--- logic/shift_pkg.sv
package shift_pkg;

    //////////////////////////////
    // Shift settings
    //////////////////////////////

    // Direction of the barrel shift
    typedef enum logic [0:0] {
        SHIFT_LEFT  = 1'b0,
        SHIFT_RIGHT = 1'b1
    } shift_dir_e;

    // Everything the shifter needs from the buttons
    typedef struct packed {
        shift_dir_e dir;
        // Set = rotate, clear = zero fill
        logic       rotate;
        logic [3:0] shamnt;
    } shift_ctrl_t;

    // Switch word and shifted word
    typedef logic [15:0] data_word_t;

    //////////////////////////////
    // Display
    //////////////////////////////

    // One hex digit on the display
    typedef logic [3:0] hex_digit_t;

    // Digits scanned by seg7_scan
    localparam int NUM_DIGITS = 4;

    // All segments dark, active low
    localparam logic [6:0] SEG_BLANK = 7'b111_1111;

endpackage

//--- logic/tick_gen.sv
`timescale 1ns/100ps

module tick_gen #(
    parameter int TICK_DIV = 100_000
) (
    input  logic clk,
    input  logic rst_n,
    output logic tick
);

    // Counter wide enough for TICK_DIV-1, at least one bit
    localparam int CNT_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;
    localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(TICK_DIV - 1);

    logic [CNT_W-1:0] cnt;

    // Free running divider, tick registered on the wrap
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt  <= '0;
            tick <= 1'b0;
        end else begin
            tick <= (cnt == CNT_MAX);
            if (cnt == CNT_MAX) begin
                cnt <= '0;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    // Tick stays a single-cycle pulse
    a_tick_single : assert property (@(posedge clk) disable iff (!rst_n)
        (TICK_DIV > 1) && tick |=> !tick);

endmodule

//--- tb/tb_barrel_display.sv
`timescale 1ns/100ps

module tb_barrel_display import shift_pkg::*;;

    localparam int TICK_DIV       = 4;
    localparam int DEBOUNCE_TICKS = 3;
    // A scan step is due every TICK_DIV cycles
    localparam int SCAN_TIMEOUT   = 3 * TICK_DIV;
    localparam logic [31:0] SEED  = 32'h43fc99a8;

    // Active low hex patterns, gfedcba
    localparam logic [6:0] SEG_TABLE [16] = '{
        7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
        7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0e
    };

    logic        clk;
    logic        rst_n;
    logic [15:0] sw;
    logic [4:0]  btn;
    logic [7:0]  led;
    logic [6:0]  seg;
    logic        dp;
    logic [7:0]  an;

    logic [31:0] lfsr;
    int          errors;
    int          checks;

    // Model of the shift settings
    shift_dir_e  m_dir;
    logic        m_rot;
    logic [3:0]  m_amt;

    barrel_display_top #(
        .TICK_DIV      (TICK_DIV),
        .DEBOUNCE_TICKS(DEBOUNCE_TICKS)
    ) u_barrel_display_top (
        .clk  (clk),
        .rst_n(rst_n),
        .sw   (sw),
        .btn  (btn),
        .led  (led),
        .seg  (seg),
        .dp   (dp),
        .an   (an)
    );

    // 25 MHz
    always #20 clk = ~clk;

    //////////////////////////////
    // Helpers
    //////////////////////////////

    // Taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // One bit per step, wraps or zero fills
    function automatic logic [15:0] shift_model(input logic [15:0] w, input shift_dir_e dir,
                                                input logic rot, input int amt);
        logic [15:0] r;
        r = w;
        for (int i = 0; i < amt; i++) begin
            if (dir == SHIFT_LEFT)
                r = {r[14:0], rot ? r[15] : 1'b0};
            else
                r = {rot ? r[0] : 1'b0, r[15:1]};
        end
        return r;
    endfunction

    function automatic logic [7:0] expected_led();
        return {m_dir, m_rot, m_amt, 2'b00};
    endfunction

    // Held 8 ticks down, 8 ticks up
    task automatic press_button(input int idx);
        @(posedge clk);
        btn[idx] <= 1'b1;
        repeat (8 * TICK_DIV) @(posedge clk);
        btn[idx] <= 1'b0;
        repeat (8 * TICK_DIV) @(posedge clk);
        case (idx)
            0: m_dir = (m_dir == SHIFT_LEFT) ? SHIFT_RIGHT : SHIFT_LEFT;
            1: m_rot = ~m_rot;
            2: m_amt[0] = ~m_amt[0];
            3: m_amt[1] = ~m_amt[1];
            default: m_amt[3:2] = m_amt[3:2] + 2'd1;
        endcase
    endtask

    // Presses only the buttons whose field differs
    task automatic set_ctrl(input shift_dir_e dir, input logic rot, input logic [3:0] amt);
        logic [1:0] steps;
        if (m_dir != dir) press_button(0);
        if (m_rot != rot) press_button(1);
        if (m_amt[0] != amt[0]) press_button(2);
        if (m_amt[1] != amt[1]) press_button(3);
        steps = amt[3:2] - m_amt[3:2];
        for (int i = 0; i < steps; i++) press_button(4);
    endtask

    task automatic wait_an_change(input string name);
        logic [7:0] prev;
        int         cycles;
        bit         seen;
        @(negedge clk);
        prev   = an;
        cycles = 0;
        seen   = 0;
        while (!seen && cycles < SCAN_TIMEOUT) begin
            @(negedge clk);
            cycles++;
            if (an != prev) seen = 1;
        end
        if (!seen) begin
            errors++;
            $display("Timeout in %s: the display did not scan within %0d cycles",
                     name, SCAN_TIMEOUT);
        end
    endtask

    // Scan order, one lit digit, and optionally its pattern
    task automatic watch_scan(input string name, input int steps, input bit check_seg,
                              input logic [15:0] word);
        int prev_idx;
        int idx;
        prev_idx = -1;
        for (int s = 0; s < steps; s++) begin
            wait_an_change(name);
            check_value({name, " one lit"}, 1, $countones(~an[3:0]));
            idx = 0;
            for (int d = 0; d < 4; d++) begin
                if (!an[d]) idx = d;
            end
            if (prev_idx >= 0)
                check_value({name, " order"}, (prev_idx + 1) % 4, idx);
            if (check_seg)
                check_value({name, " seg"}, SEG_TABLE[word[4*idx +: 4]], seg);
            prev_idx = idx;
        end
    endtask

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    initial begin
        logic [31:0] r;
        logic [1:0]  start_hi;
        logic [15:0] word;
        shift_dir_e  dir;
        clk    = 1'b0;
        rst_n  = 1'b0;
        sw     = '0;
        btn    = '0;
        lfsr   = SEED;
        errors = 0;
        checks = 0;
        m_dir  = SHIFT_LEFT;
        m_rot  = 1'b0;
        m_amt  = '0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        // Reset state, still before the first tick
        @(negedge clk);
        check_value("reset led", 8'h00, led);
        check_value("reset dp", 1'b1, dp);
        check_value("reset an", 8'hff, an);
        check_value("reset seg", 7'h7f, seg);

        // Random toggles of buttons 0 to 3
        for (int i = 0; i < 12; i++) begin
            rand_bits(2, r);
            press_button(int'(r[1:0]));
            @(negedge clk);
            check_value("toggle led", expected_led(), led);
        end

        // High shift pair counts and wraps
        start_hi = m_amt[3:2];
        for (int i = 0; i < 5; i++) begin
            press_button(4);
            @(negedge clk);
            check_value("count led", m_amt[3:2], led[5:4]);
        end
        check_value("count wrap", start_hi + 2'd1, led[5:4]);

        watch_scan("scan", 16, 1'b0, '0);

        // Every mode and amount with a random word
        for (int mode = 0; mode < 4; mode++) begin
            dir = mode[1] ? SHIFT_RIGHT : SHIFT_LEFT;
            for (int k = 0; k < 16; k++) begin
                set_ctrl(dir, mode[0], 4'(k));
                @(negedge clk);
                check_value("shift led", expected_led(), led);
                rand_bits(16, r);
                word = r[15:0];
                @(posedge clk);
                sw <= word;
                // Register, then one full scan
                for (int s = 0; s < 5; s++) wait_an_change("settle");
                watch_scan("shift", 8, 1'b1, shift_model(word, m_dir, m_rot, int'(m_amt)));
            end
        end

        // Pulse shorter than a tick is dropped
        for (int i = 0; i < 6; i++) begin
            rand_bits(3, r);
            @(posedge clk);
            btn[int'(r[2:0]) % 5] <= 1'b1;
            repeat (TICK_DIV - 1) @(posedge clk);
            btn <= '0;
            repeat (8 * TICK_DIV) @(posedge clk);
            @(negedge clk);
            check_value("glitch led", expected_led(), led);
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule
